//--- all.f
src/rom_pkg.sv
src/rom_slot_cache.sv
src/rom_slot_arbiter.sv
src/rom_slots_top.sv
tb/tb_axil_rom_model.sv
tb/tb_rom_slots.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then search the log for the fail line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rom_slots \
    -Mdir obj_dir -f all.f > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_rom_slots > sim.log 2>&1 \
    || { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "no result line found in sim.log"; exit 1; }
echo "simulation passed"

//--- src/rom_pkg.sv
package rom_pkg;

    // memory is addressed in 32-bit words on the client side
    localparam int ROM_WAW = 22;

    // byte address on the AXI side, word address times four
    localparam int AXI_AW = ROM_WAW + 2;

    localparam int ROM_DW = 32;

    // client slots sharing the read port
    localparam int SLOTS = 4;

    // one memory word seen as bytes or as halfwords
    // b[0] and h[0] sit at the lowest byte address (little endian)
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } rom_word_t;

endpackage

//--- src/rom_slot_arbiter.sv
`timescale 1ns/1ps

module rom_slot_arbiter import rom_pkg::*; #(
    parameter int SLOTS = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          vblank,
    input  logic                          downloading,
    input  logic [SLOTS-1:0]              req,
    input  logic [SLOTS-1:0][ROM_WAW-1:0] word_addr,
    output logic [SLOTS-1:0]              fill,
    output logic [ROM_DW-1:0]             fill_data,
    output logic [AXI_AW-1:0]             araddr,
    output logic                          arvalid,
    input  logic                          arready,
    input  logic [ROM_DW-1:0]             rdata,
    input  logic [1:0]                    rresp,
    input  logic                          rvalid,
    output logic                          rready,
    output logic                          refresh_en,
    output logic                          bus_err
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ADDR = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;

    localparam int IW = (SLOTS > 1) ? $clog2(SLOTS) : 1;

    logic [1:0]         state;
    logic [IW-1:0]      sel;        // slot being served
    logic [ROM_WAW-1:0] rd_addr;    // word address sent on the bus
    logic [IW-1:0]      pick;
    logic               take;
    logic               beat;

    // lowest slot number wins
    always_comb begin
        pick = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (req[i]) begin
                pick = IW'(i);
            end
        end
    end

    assign take = (state == ST_IDLE) && (|req) && !downloading;
    assign beat = (state == ST_DATA) && rvalid;    // rready is high in ST_DATA

    assign araddr    = {rd_addr, 2'b00};
    assign fill_data = rdata;

    // a slot that moved on to another word, or a download, drops the data
    always_comb begin
        fill = '0;
        if (beat && !downloading && (word_addr[sel] == rd_addr)) begin
            fill[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            refresh_en <= 1'b0;
            bus_err    <= 1'b0;
        end else begin
            refresh_en <= (state == ST_IDLE) && !(|req) && vblank;
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        arvalid <= 1'b1;
                        state   <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    // address stays put until the memory takes it
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (rvalid) begin
                        rready <= 1'b0;
                        state  <= ST_IDLE;
                        if (rresp != 2'b00) begin
                            bus_err <= 1'b1;    // sticky
                        end
                    end
                end
                default: begin
                    arvalid <= 1'b0;
                    rready  <= 1'b0;
                    state   <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            sel     <= pick;
            rd_addr <= word_addr[pick];
        end
    end

endmodule

//--- src/rom_slot_cache.sv
`timescale 1ns/1ps

module rom_slot_cache import rom_pkg::*; #(
    parameter int                 AW     = 8,
    parameter int                 DW     = 8,
    parameter logic [ROM_WAW-1:0] OFFSET = '0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               downloading,
    input  logic [AW-1:0]      addr,
    input  logic               cs,
    output logic [ROM_WAW-1:0] word_addr,
    output logic               req,
    input  logic               fill,
    input  logic [ROM_DW-1:0]  fill_data,
    output logic [DW-1:0]      dout,
    output logic               ok
);

    // client units per word decide how far the address moves
    localparam int SH = (DW == 8) ? 2 : ((DW == 16) ? 1 : 0);

    logic               valid;
    logic [ROM_WAW-1:0] tag;        // word address of the cached word
    rom_word_t          cword;
    logic               match;

    assign word_addr = OFFSET + ROM_WAW'(addr >> SH);

    // nothing counts as cached while a download is running
    assign match = valid && (tag == word_addr) && !downloading;

    assign ok  = cs && match;
    assign req = cs && !match && !downloading;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (downloading) begin
            valid <= 1'b0;          // memory contents are changing
        end else if (fill) begin
            valid <= 1'b1;
        end
    end

    // arbiter only fills when word_addr still equals the fetched address
    always_ff @(posedge clk) begin
        if (fill) begin
            tag   <= word_addr;
            cword <= fill_data;
        end
    end

    // pick the slot's data unit out of the cached word
    generate
        if (DW == 8) begin : g_byte
            assign dout = cword.b[addr[1:0]];
        end else if (DW == 16) begin : g_half
            assign dout = cword.h[addr[0]];
        end else begin : g_word
            assign dout = cword;    // full 32-bit slot
        end
    endgenerate

endmodule

//--- src/rom_slots_top.sv
`timescale 1ns/1ps

module rom_slots_top import rom_pkg::*; #(
    parameter int                 SLOT0_AW     = 8,
    parameter int                 SLOT0_DW     = 8,
    parameter logic [ROM_WAW-1:0] SLOT0_OFFSET = '0,
    parameter int                 SLOT1_AW     = 8,
    parameter int                 SLOT1_DW     = 8,
    parameter logic [ROM_WAW-1:0] SLOT1_OFFSET = '0,
    parameter int                 SLOT2_AW     = 8,
    parameter int                 SLOT2_DW     = 8,
    parameter logic [ROM_WAW-1:0] SLOT2_OFFSET = '0,
    parameter int                 SLOT3_AW     = 8,
    parameter int                 SLOT3_DW     = 8,
    parameter logic [ROM_WAW-1:0] SLOT3_OFFSET = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                vblank,
    input  logic                downloading,

    // client slots, slot 0 has top priority
    input  logic                slot0_cs,
    input  logic [SLOT0_AW-1:0] slot0_addr,
    output logic [SLOT0_DW-1:0] slot0_dout,
    output logic                slot0_ok,
    input  logic                slot1_cs,
    input  logic [SLOT1_AW-1:0] slot1_addr,
    output logic [SLOT1_DW-1:0] slot1_dout,
    output logic                slot1_ok,
    input  logic                slot2_cs,
    input  logic [SLOT2_AW-1:0] slot2_addr,
    output logic [SLOT2_DW-1:0] slot2_dout,
    output logic                slot2_ok,
    input  logic                slot3_cs,
    input  logic [SLOT3_AW-1:0] slot3_addr,
    output logic [SLOT3_DW-1:0] slot3_dout,
    output logic                slot3_ok,

    // AXI4-Lite read master
    output logic [AXI_AW-1:0]   araddr,
    output logic                arvalid,
    input  logic                arready,
    input  logic [ROM_DW-1:0]   rdata,
    input  logic [1:0]          rresp,
    input  logic                rvalid,
    output logic                rready,

    output logic                refresh_en,
    output logic                bus_err
);

    logic [SLOTS-1:0]              req;
    logic [SLOTS-1:0]              fill;
    logic [SLOTS-1:0][ROM_WAW-1:0] word_addr;
    logic [ROM_DW-1:0]             fill_data;   // shared by all caches

    rom_slot_cache #(.AW(SLOT0_AW), .DW(SLOT0_DW), .OFFSET(SLOT0_OFFSET)) u_slot0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .addr        (slot0_addr),
        .cs          (slot0_cs),
        .word_addr   (word_addr[0]),
        .req         (req[0]),
        .fill        (fill[0]),
        .fill_data   (fill_data),
        .dout        (slot0_dout),
        .ok          (slot0_ok)
    );

    rom_slot_cache #(.AW(SLOT1_AW), .DW(SLOT1_DW), .OFFSET(SLOT1_OFFSET)) u_slot1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .addr        (slot1_addr),
        .cs          (slot1_cs),
        .word_addr   (word_addr[1]),
        .req         (req[1]),
        .fill        (fill[1]),
        .fill_data   (fill_data),
        .dout        (slot1_dout),
        .ok          (slot1_ok)
    );

    rom_slot_cache #(.AW(SLOT2_AW), .DW(SLOT2_DW), .OFFSET(SLOT2_OFFSET)) u_slot2 (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .addr        (slot2_addr),
        .cs          (slot2_cs),
        .word_addr   (word_addr[2]),
        .req         (req[2]),
        .fill        (fill[2]),
        .fill_data   (fill_data),
        .dout        (slot2_dout),
        .ok          (slot2_ok)
    );

    rom_slot_cache #(.AW(SLOT3_AW), .DW(SLOT3_DW), .OFFSET(SLOT3_OFFSET)) u_slot3 (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .addr        (slot3_addr),
        .cs          (slot3_cs),
        .word_addr   (word_addr[3]),
        .req         (req[3]),
        .fill        (fill[3]),
        .fill_data   (fill_data),
        .dout        (slot3_dout),
        .ok          (slot3_ok)
    );

    rom_slot_arbiter #(.SLOTS(SLOTS)) u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .vblank      (vblank),
        .downloading (downloading),
        .req         (req),
        .word_addr   (word_addr),
        .fill        (fill),
        .fill_data   (fill_data),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .refresh_en  (refresh_en),
        .bus_err     (bus_err)
    );

endmodule

//--- tb/tb_axil_rom_model.sv
`timescale 1ns/1ps

module tb_axil_rom_model import rom_pkg::*; #(
    parameter int                MAX_DELAY = 5,
    parameter logic [AXI_AW-1:0] ERR_BASE  = 24'h80_0000
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [AXI_AW-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [ROM_DW-1:0] rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready
);

    // word contents derived from the word address, one xor mask per halfword
    function automatic rom_word_t word_at(input logic [ROM_WAW-1:0] wa);
        rom_word_t w;
        w.h[0] = wa[15:0] ^ 16'hc35a;
        w.h[1] = {wa[21:16], wa[9:0]} ^ 16'h9e37;
        return w;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // one read at a time, outputs change on the falling edge only
    initial begin
        logic [AXI_AW-1:0] addr;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = 2'b00;
        forever begin
            @(negedge clk);
            if (rst_n && arvalid) begin
                idle_cycles($urandom_range(MAX_DELAY, 0));
                addr    = araddr;           // held steady until arready
                arready = 1'b1;             // handshake on the next rising edge
                @(negedge clk);
                arready = 1'b0;

                idle_cycles($urandom_range(MAX_DELAY - 1, 0));
                rdata  = word_at(addr[AXI_AW-1:2]);
                rresp  = (addr >= ERR_BASE) ? 2'b10 : 2'b00;   // SLVERR above the base
                rvalid = 1'b1;

                // beat completes on the first rising edge with rready high
                while (!rready) begin
                    @(negedge clk);
                end
                @(negedge clk);
                rvalid = 1'b0;
                rresp  = 2'b00;
            end
        end
    end

endmodule

//--- tb/tb_rom_slots.sv
`timescale 1ns/1ps

module tb_rom_slots import rom_pkg::*; ();

    localparam int          CLK_NS      = 8;
    localparam int          RST_CYCLES  = 16;
    localparam int          MAX_DELAY   = 5;
    localparam int          ROUNDS      = 80;
    localparam int          DL_EVERY    = 16;       // a download after every 16th round
    localparam int          DL_CYCLES   = 12;
    localparam logic [31:0] SEED        = 32'hd5d2_f0e9;

    localparam int READ_CYCLES = 2 * MAX_DELAY + 4;             // worst case for one read
    localparam int WAIT_BOUND  = (SLOTS + 1) * READ_CYCLES + 4; // own read behind all others
    localparam int N_DL        = ROUNDS / DL_EVERY;
    localparam int XACTS       = ROUNDS * SLOTS + N_DL * (SLOTS + 1);
    localparam int TIMEOUT_NS  =
        ((XACTS * READ_CYCLES + N_DL * DL_CYCLES) * 2 + RST_CYCLES) * CLK_NS;

    localparam logic [ROM_WAW-1:0] S0_OFF = 22'h00_0100;
    localparam logic [ROM_WAW-1:0] S1_OFF = 22'h00_1000;
    localparam logic [ROM_WAW-1:0] S2_OFF = 22'h01_0000;
    localparam logic [ROM_WAW-1:0] S3_OFF = 22'h20_0040;  // inside the error range

    logic clk;
    logic rst_n;
    logic vblank;
    logic downloading;
    logic        slot0_cs, slot1_cs, slot2_cs, slot3_cs;
    logic [9:0]  slot0_addr;
    logic [9:0]  slot1_addr;
    logic [7:0]  slot2_addr;
    logic [9:0]  slot3_addr;
    logic [7:0]  slot0_dout;
    logic [15:0] slot1_dout;
    logic [31:0] slot2_dout;
    logic [7:0]  slot3_dout;
    logic        slot0_ok, slot1_ok, slot2_ok, slot3_ok;
    logic [AXI_AW-1:0] araddr;
    logic              arvalid, arready, rvalid, rready;
    logic [ROM_DW-1:0] rdata;
    logic [1:0]        rresp;
    logic              refresh_en, bus_err;

    logic                          hit_check;   // repeat access, must hit at once
    logic [SLOTS-1:0]              cs_vec, ok_vec, pend_vec;
    logic [SLOTS-1:0][ROM_WAW-1:0] exp_wa;
    logic                          any_pending;
    logic [AXI_AW-1:0]             first_araddr;
    logic [7:0]                    exp0, exp3;
    logic [15:0]                   exp1;
    logic [31:0]                   exp2;
    int                            wait_cnt [SLOTS];
    int                            errors = 0;

    rom_slots_top #(
        .SLOT0_AW(10), .SLOT0_DW(8),  .SLOT0_OFFSET(S0_OFF),
        .SLOT1_AW(10), .SLOT1_DW(16), .SLOT1_OFFSET(S1_OFF),
        .SLOT2_AW(8),  .SLOT2_DW(32), .SLOT2_OFFSET(S2_OFF),
        .SLOT3_AW(10), .SLOT3_DW(8),  .SLOT3_OFFSET(S3_OFF)
    ) i_dut (
        .clk(clk), .rst_n(rst_n), .vblank(vblank), .downloading(downloading),
        .slot0_cs(slot0_cs), .slot0_addr(slot0_addr), .slot0_dout(slot0_dout), .slot0_ok(slot0_ok),
        .slot1_cs(slot1_cs), .slot1_addr(slot1_addr), .slot1_dout(slot1_dout), .slot1_ok(slot1_ok),
        .slot2_cs(slot2_cs), .slot2_addr(slot2_addr), .slot2_dout(slot2_dout), .slot2_ok(slot2_ok),
        .slot3_cs(slot3_cs), .slot3_addr(slot3_addr), .slot3_dout(slot3_dout), .slot3_ok(slot3_ok),
        .araddr(araddr), .arvalid(arvalid), .arready(arready), .rdata(rdata),
        .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .refresh_en(refresh_en), .bus_err(bus_err)
    );

    tb_axil_rom_model #(.MAX_DELAY(MAX_DELAY)) i_mem (
        .clk(clk), .rst_n(rst_n), .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    // memory word rule: halfwords are address bits xor fixed masks
    function automatic logic [31:0] mem_word(input logic [ROM_WAW-1:0] wa);
        logic [15:0] lo;
        logic [15:0] hi;
        lo = wa[15:0] ^ 16'hc35a;
        hi = {wa[21:16], wa[9:0]} ^ 16'h9e37;
        return {hi, lo};
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // expected translation and data per slot
    always_comb begin
        exp_wa[0] = S0_OFF + ROM_WAW'(slot0_addr >> 2);
        exp_wa[1] = S1_OFF + ROM_WAW'(slot1_addr >> 1);
        exp_wa[2] = S2_OFF + ROM_WAW'(slot2_addr);
        exp_wa[3] = S3_OFF + ROM_WAW'(slot3_addr >> 2);
        exp0 = 8'(mem_word(exp_wa[0]) >> (8 * slot0_addr[1:0]));
        exp1 = 16'(mem_word(exp_wa[1]) >> (16 * slot1_addr[0]));
        exp2 = mem_word(exp_wa[2]);
        exp3 = 8'(mem_word(exp_wa[3]) >> (8 * slot3_addr[1:0]));
    end

    assign cs_vec   = {slot3_cs, slot2_cs, slot1_cs, slot0_cs};
    assign ok_vec   = {slot3_ok, slot2_ok, slot1_ok, slot0_ok};
    assign pend_vec = cs_vec & ~ok_vec & {SLOTS{!downloading}};

    // lowest pending slot should be the next one on the bus
    always_comb begin
        any_pending  = 1'b0;
        first_araddr = '0;
        for (int n = SLOTS - 1; n >= 0; n--) begin
            if (pend_vec[n]) begin
                any_pending  = 1'b1;
                first_araddr = {exp_wa[n], 2'b00};
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int n = 0; n < SLOTS; n++) begin
            if (!rst_n || !cs_vec[n] || ok_vec[n] || downloading) begin
                wait_cnt[n] <= 0;
            end else begin
                wait_cnt[n] <= wait_cnt[n] + 1;
            end
        end
    end

    assert property (@(posedge clk) !rst_n |->
        !arvalid && !rready && !refresh_en && !bus_err && !(|ok_vec))
        else flag_error("outputs not idle during reset");

    assert property (@(posedge clk) disable iff (!rst_n)
        slot0_cs && slot0_ok |-> slot0_dout == exp0)
        else flag_error("slot0 byte differs from memory");
    assert property (@(posedge clk) disable iff (!rst_n)
        slot1_cs && slot1_ok |-> slot1_dout == exp1)
        else flag_error("slot1 halfword differs from memory");
    assert property (@(posedge clk) disable iff (!rst_n)
        slot2_cs && slot2_ok |-> slot2_dout == exp2)
        else flag_error("slot2 word differs from memory");
    assert property (@(posedge clk) disable iff (!rst_n)
        slot3_cs && slot3_ok |-> slot3_dout == exp3)
        else flag_error("slot3 byte differs from memory");

    for (genvar n = 0; n < SLOTS; n++) begin : g_progress
        assert property (@(posedge clk) disable iff (!rst_n) wait_cnt[n] < WAIT_BOUND)
            else flag_error($sformatf("slot%0d ok did not rise in time", n));
    end

    assert property (@(posedge clk) disable iff (!rst_n) hit_check |-> (ok_vec & cs_vec) == cs_vec)
        else flag_error("repeat access to the cached word missed");
    assert property (@(posedge clk) disable iff (!rst_n) hit_check |=> !arvalid)
        else flag_error("repeat access caused a bus read");

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(arvalid) |-> $past(any_pending) && araddr == $past(first_araddr))
        else flag_error("read address is not the lowest pending slot");

    assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else flag_error("araddr or arvalid changed before arready");
    assert property (@(posedge clk) disable iff (!rst_n) $rose(arvalid) |-> !$past(downloading))
        else flag_error("read started during download");
    assert property (@(posedge clk) disable iff (!rst_n) downloading |-> !(|ok_vec))
        else flag_error("ok high during download");

    assert property (@(posedge clk) disable iff (!rst_n)
        refresh_en |-> $past(vblank) && !$past(any_pending))
        else flag_error("refresh_en without vblank or with a pending request");
    // no read outstanding on the bus means the arbiter is idle
    assert property (@(posedge clk) disable iff (!rst_n)
        vblank && !any_pending && !arvalid && !rready |=> refresh_en)
        else flag_error("refresh_en missing in an idle vblank cycle");

    assert property (@(posedge clk) disable iff (!rst_n) bus_err |=> bus_err)
        else flag_error("bus_err dropped");
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus_err) |-> $past(rvalid && rready && rresp != 2'b00))
        else flag_error("bus_err rose without an error response");
    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && rready && rresp != 2'b00 |=> bus_err)
        else flag_error("bus_err missing after an error response");

    task automatic drive_slots(input bit all_cs);
        slot0_cs   = all_cs || ($urandom_range(3, 0) != 0);
        slot1_cs   = all_cs || ($urandom_range(3, 0) != 0);
        slot2_cs   = all_cs || ($urandom_range(3, 0) != 0);
        slot3_cs   = all_cs || ($urandom_range(7, 0) == 0);  // rare, error range
        slot0_addr = 10'($urandom);
        slot1_addr = 10'($urandom);
        slot2_addr = 8'($urandom);
        slot3_addr = 10'($urandom);
        vblank     = 1'($urandom);
    endtask

    // ok is the slot's done signal
    task automatic wait_all_ok();
        do begin
            @(negedge clk);
        end while ((ok_vec & cs_vec) != cs_vec);
    endtask

    task automatic run_round();
        @(negedge clk);
        drive_slots(1'b0);
        wait_all_ok();
        // other unit inside the same word, slot2 keeps its word
        slot0_addr[1:0] = slot0_addr[1:0] + 2'd1;
        slot1_addr[0]   = ~slot1_addr[0];
        slot3_addr[1:0] = slot3_addr[1:0] + 2'd3;
        hit_check = 1'b1;
        @(negedge clk);
        hit_check = 1'b0;
    endtask

    task automatic run_download();
        @(negedge clk);
        drive_slots(1'b1);
        do begin
            @(negedge clk);
        end while (!arvalid && ((ok_vec & cs_vec) != cs_vec));
        downloading = 1'b1;             // read in flight gets dropped
        repeat (DL_CYCLES) begin
            @(negedge clk);
            drive_slots(1'b1);
        end
        downloading = 1'b0;
        wait_all_ok();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, a slot or the bus stopped responding",
                 TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst_n       = 1'b1;
        vblank      = 1'b0;
        downloading = 1'b0;
        hit_check   = 1'b0;
        slot0_cs    = 1'b0;
        slot1_cs    = 1'b0;
        slot2_cs    = 1'b0;
        slot3_cs    = 1'b0;
        slot0_addr  = '0;
        slot1_addr  = '0;
        slot2_addr  = '0;
        slot3_addr  = '0;
        #1 rst_n = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        for (int r = 0; r < ROUNDS; r++) begin
            run_round();
            if (r % DL_EVERY == DL_EVERY - 1) begin
                run_download();
            end
        end
        repeat (4) @(negedge clk);

        $display("summary: %0d rounds, %0d downloads, %0d errors", ROUNDS, N_DL, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
